// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= all.f
TB_TOP    ?= rs_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o sim_$(TB_TOP)
	@out="$$(./$(OBJ_DIR)/sim_$(TB_TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+hdl
hdl/rs_op_pkg.sv
hdl/rs_entry_pkg.sv
hdl/rs_if.sv
hdl/rs_control.sv
hdl/rs_bank.sv
hdl/rs_top.sv
dv/rs_sva.sv
dv/rs_tb.sv

// File: dv/rs_sva.sv
`timescale 1ns/1ps

module rs_sva (
    input logic clk,
    input logic rst,
    input logic alu_fu_busy,
    input logic mul_fu_busy,
    input logic alu_issue_valid,
    input logic mul_issue_valid,
    input logic alu_credit,
    input logic mul_credit
);
    int fail_count = 0;

    // a busy unit takes nothing
    alu_busy_hold: assert property (@(posedge clk) disable iff (rst)
        alu_fu_busy |-> !alu_issue_valid)
        else begin fail_count++; $error("alu issued while its unit was busy"); end
    mul_busy_hold: assert property (@(posedge clk) disable iff (rst)
        mul_fu_busy |-> !mul_issue_valid)
        else begin fail_count++; $error("mul issued while its unit was busy"); end

    // every credit traces back to an issue one cycle earlier
    alu_credit_src: assert property (@(posedge clk) disable iff (rst)
        alu_credit |-> $past(alu_issue_valid))
        else begin fail_count++; $error("alu credit without an issue"); end
    mul_credit_src: assert property (@(posedge clk) disable iff (rst)
        mul_credit |-> $past(mul_issue_valid))
        else begin fail_count++; $error("mul credit without an issue"); end

    quiet_after_rst: assert property (@(posedge clk)
        $fell(rst) |-> !alu_issue_valid && !mul_issue_valid && !alu_credit && !mul_credit)
        else begin fail_count++; $error("outputs active in the first cycle after reset"); end

endmodule

bind rs_top rs_sva u_sva (
    .clk             (clk),
    .rst             (rst),
    .alu_fu_busy     (alu_fu_busy),
    .mul_fu_busy     (mul_fu_busy),
    .alu_issue_valid (alu_issue_valid),
    .mul_issue_valid (mul_issue_valid),
    .alu_credit      (alu_credit),
    .mul_credit      (mul_credit)
);

// File: dv/rs_tb.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_tb
    import rs_op_pkg::*;
    import rs_entry_pkg::*;
();
    logic clk, rst;
    logic dispatch_valid, dispatch_ps1_ready, dispatch_ps2_ready;
    opcode_e dispatch_op;
    tag_t dispatch_ps1, dispatch_ps2, dispatch_pd, cdb0_tag, cdb1_tag;
    rob_idx_t dispatch_rob;
    logic cdb0_valid, cdb1_valid, alu_fu_busy, mul_fu_busy;
    logic alu_issue_valid, mul_issue_valid, alu_credit, mul_credit;
    opcode_e alu_issue_op, mul_issue_op;
    tag_t alu_issue_ps1, alu_issue_ps2, alu_issue_pd, mul_issue_ps1, mul_issue_ps2, mul_issue_pd;
    rob_idx_t alu_issue_rob, mul_issue_rob;

    logic [15:0] lfsr = 16'd7100;
    int errors = 0;
    int checks = 0;
    int alu_cred, mul_cred;            // dispatcher side credit counters
    int depth [2];
    int disp_cnt [2];
    int issue_cnt [2];                 // issues seen on the DUT outputs
    tag_t next_pd;
    rob_idx_t next_rob;
    tag_t live_q [$];                  // dispatched pds not yet broadcast
    tag_t bcast_q [$];                 // issued pds waiting for a CDB port
    logic fu_busy_now [2];
    logic exp_credit [2];

    // reference copy of both banks with index 0 for ALU and 1 for multiply
    logic m_busy [2][`RS_ALU_DEPTH];
    logic m_r1 [2][`RS_ALU_DEPTH];
    logic m_r2 [2][`RS_ALU_DEPTH];
    opcode_e m_op [2][`RS_ALU_DEPTH];
    tag_t m_ps1 [2][`RS_ALU_DEPTH];
    tag_t m_ps2 [2][`RS_ALU_DEPTH];
    tag_t m_pd [2][`RS_ALU_DEPTH];
    rob_idx_t m_rob [2][`RS_ALU_DEPTH];

    rs_top uut (.*);

    always #4 clk = ~clk;

    // taps of x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        logic fb;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v = (v << 1) | int'(fb);
        end
        return v;
    endfunction

    function automatic logic pick_busy(input int mode);
        if (mode == 2)
            return rand_bits(2) == 0;  // busy a quarter of the time
        return mode == 1;
    endfunction

    function automatic logic on_cdb(input tag_t t);
        return (cdb0_valid && cdb0_tag == t) || (cdb1_valid && cdb1_tag == t);
    endfunction

    function automatic int ready_slot(input int b);
        for (int i = 0; i < depth[b]; i++)
        begin
            if (m_busy[b][i] && m_r1[b][i] && m_r2[b][i])
                return i;
        end
        return -1;
    endfunction

    function automatic int free_slot(input int b);
        for (int i = 0; i < depth[b]; i++)
        begin
            if (!m_busy[b][i])
                return i;
        end
        return -1;
    endfunction

    function automatic logic bank_empty(input int b);
        for (int i = 0; i < depth[b]; i++)
        begin
            if (m_busy[b][i])
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("Error: %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bank(input int b, input string pre, input logic v, input opcode_e op,
                              input tag_t ps1, input tag_t ps2, input tag_t pd,
                              input rob_idx_t rob, input logic cr);
        int s;
        logic ev;
        s = ready_slot(b);
        ev = (s >= 0) && !fu_busy_now[b];
        compare_field({pre, "_issue_valid"}, 32'(v), 32'(ev));
        compare_field({pre, "_credit"}, 32'(cr), 32'(exp_credit[b]));
        if (ev && v)
        begin
            compare_field({pre, "_issue_op"}, 32'(op), 32'(m_op[b][s]));
            compare_field({pre, "_issue_ps1"}, 32'(ps1), 32'(m_ps1[b][s]));
            compare_field({pre, "_issue_ps2"}, 32'(ps2), 32'(m_ps2[b][s]));
            compare_field({pre, "_issue_pd"}, 32'(pd), 32'(m_pd[b][s]));
            compare_field({pre, "_issue_rob"}, 32'(rob), 32'(m_rob[b][s]));
        end
        if (v === 1'b1)
            issue_cnt[b]++;
    endtask

    // state as it stands after the coming rising edge
    task automatic advance_bank(input int b, input logic wr);
        int s;
        int f;
        s = ready_slot(b);
        f = free_slot(b);  // taken before the issuing slot frees
        exp_credit[b] = (s >= 0) && !fu_busy_now[b];
        for (int i = 0; i < depth[b]; i++)
        begin
            if (on_cdb(m_ps1[b][i]))
                m_r1[b][i] = 1'b1;
            if (on_cdb(m_ps2[b][i]))
                m_r2[b][i] = 1'b1;
        end
        if (exp_credit[b])
        begin
            m_busy[b][s] = 1'b0;
            bcast_q.push_back(m_pd[b][s]);
        end
        if (wr && f < 0)
        begin
            $display("dispatch was sent to bank %0d while it had no free slot", b);
            errors++;
        end
        else if (wr)
        begin
            m_busy[b][f] = 1'b1;
            m_op[b][f] = dispatch_op;
            m_ps1[b][f] = dispatch_ps1;
            m_ps2[b][f] = dispatch_ps2;
            m_r1[b][f] = dispatch_ps1_ready || on_cdb(dispatch_ps1);  // bypass
            m_r2[b][f] = dispatch_ps2_ready || on_cdb(dispatch_ps2);
            m_pd[b][f] = dispatch_pd;
            m_rob[b][f] = dispatch_rob;
        end
    endtask

    task automatic drop_live(input tag_t t);
        for (int i = 0; i < live_q.size(); i++)
        begin
            if (live_q[i] == t)
            begin
                live_q.delete(i);
                break;
            end
        end
    endtask

    // one clock cycle where each busy mode is 0 low, 1 high or 2 random
    task automatic step(input logic disp_en, input int alu_mode, input int mul_mode);
        int u;
        @(negedge clk);
        rst = 1'b0;
        if (alu_credit)
            alu_cred++;
        if (mul_credit)
            mul_cred++;
        fu_busy_now[0] = pick_busy(alu_mode);
        fu_busy_now[1] = pick_busy(mul_mode);
        alu_fu_busy = fu_busy_now[0];
        mul_fu_busy = fu_busy_now[1];
        dispatch_op = opcode_e'(3'(rand_bits(3) % 7));
        u = (dispatch_op == op_mul || dispatch_op == op_mulh) ? 1 : 0;
        dispatch_valid = disp_en && (rand_bits(1) != 0) &&
                         ((u == 0) ? alu_cred > 0 : mul_cred > 0);
        // unready sources wait on pds still in flight
        dispatch_ps1_ready = (rand_bits(1) != 0) || (live_q.size() == 0);
        dispatch_ps1 = dispatch_ps1_ready ? tag_t'(rand_bits(6)) :
                       live_q[rand_bits(3) % live_q.size()];
        dispatch_ps2_ready = (rand_bits(1) != 0) || (live_q.size() == 0);
        dispatch_ps2 = dispatch_ps2_ready ? tag_t'(rand_bits(6)) :
                       live_q[rand_bits(3) % live_q.size()];
        dispatch_pd = next_pd;
        dispatch_rob = next_rob;
        if (dispatch_valid)
        begin
            disp_cnt[u]++;
            if (u == 0)
                alu_cred--;
            else
                mul_cred--;
            live_q.push_back(next_pd);
            next_pd++;
            next_rob++;
        end
        cdb0_valid = (bcast_q.size() > 0) && (rand_bits(1) != 0);
        cdb0_tag = cdb0_valid ? bcast_q.pop_front() : tag_t'(rand_bits(6));
        cdb1_valid = (bcast_q.size() > 0) && (rand_bits(1) != 0);
        cdb1_tag = cdb1_valid ? bcast_q.pop_front() : tag_t'(rand_bits(6));
        if (cdb0_valid)
            drop_live(cdb0_tag);
        if (cdb1_valid)
            drop_live(cdb1_tag);
        #1;
        check_bank(0, "alu", alu_issue_valid, alu_issue_op, alu_issue_ps1, alu_issue_ps2,
                   alu_issue_pd, alu_issue_rob, alu_credit);
        check_bank(1, "mul", mul_issue_valid, mul_issue_op, mul_issue_ps1, mul_issue_ps2,
                   mul_issue_pd, mul_issue_rob, mul_credit);
        advance_bank(0, dispatch_valid && u == 0);
        advance_bank(1, dispatch_valid && u == 1);
    endtask

    // hold one unit busy until its bank is full and a few cycles more
    task automatic hold_unit(input int b);
        int n;
        n = 0;
        while (((b == 0) ? alu_cred : mul_cred) > 0 && n < 200)
        begin
            step(1'b1, (b == 0) ? 1 : 2, (b == 1) ? 1 : 2);
            n++;
        end
        if (n == 200)
        begin
            $display("bank %0d never filled while its unit was held busy", b);
            errors++;
        end
        repeat (4) step(1'b1, (b == 0) ? 1 : 0, (b == 1) ? 1 : 0);
    endtask

    initial
    begin
        int n;
        clk = 1'b0;
        rst = 1'b1;
        {dispatch_valid, dispatch_ps1_ready, dispatch_ps2_ready} = '0;
        dispatch_op = op_add;
        {dispatch_ps1, dispatch_ps2, dispatch_pd, dispatch_rob} = '0;
        {cdb0_valid, cdb1_valid, cdb0_tag, cdb1_tag} = '0;
        {alu_fu_busy, mul_fu_busy} = '0;
        depth[0] = `RS_ALU_DEPTH;
        depth[1] = `RS_MUL_DEPTH;
        alu_cred = `RS_ALU_DEPTH;
        mul_cred = `RS_MUL_DEPTH;
        next_pd = '0;
        next_rob = '0;
        for (int b = 0; b < 2; b++)
        begin
            exp_credit[b] = 1'b0;
            disp_cnt[b] = 0;
            issue_cnt[b] = 0;
            for (int i = 0; i < `RS_ALU_DEPTH; i++)
                m_busy[b][i] = 1'b0;
        end
        repeat (3) @(posedge clk);
        repeat (8) step(1'b0, 0, 0);      // idle after reset
        repeat (300) step(1'b1, 2, 2);
        hold_unit(1);
        hold_unit(0);
        repeat (300) step(1'b1, 2, 2);
        n = 0;
        while (!(bank_empty(0) && bank_empty(1) && alu_cred == `RS_ALU_DEPTH &&
                 mul_cred == `RS_MUL_DEPTH) && n < 300)
        begin
            step(1'b0, 0, 0);
            n++;
        end
        if (n == 300)
        begin
            $display("banks did not drain or credits did not all return in time");
            errors++;
        end
        for (int b = 0; b < 2; b++)
        begin
            if (disp_cnt[b] != issue_cnt[b])
            begin
                $display("bank %0d took %0d instructions but issued %0d", b, disp_cnt[b],
                         issue_cnt[b]);
                errors++;
            end
        end
        $display("checks %0d, errors %0d, assertion failures %0d, issued alu %0d mul %0d",
                 checks, errors, uut.u_sva.fail_count, issue_cnt[0], issue_cnt[1]);
        if (errors == 0 && uut.u_sva.fail_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: hdl/rs_bank.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_bank
    import rs_op_pkg::*;
    import rs_entry_pkg::*;
#(
    parameter int DEPTH = 4
)(
    input  logic     clk,
    input  logic     rst,

    dispatch_if.sink disp,
    cdb_if.sink      cdb,

    input  logic     grant,
    output logic     req,
    output opcode_e  issue_op,
    output tag_t     issue_ps1,
    output tag_t     issue_ps2,
    output tag_t     issue_pd,
    output rob_idx_t issue_rob
);

    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    rs_entry_t        ent [DEPTH];
    logic [DEPTH-1:0] s1_hit;      // stored ps1 seen on a CDB port
    logic [DEPTH-1:0] s2_hit;
    logic             new_s1_hit;  // bypass for the entry being written
    logic             new_s2_hit;
    logic [IDX_W-1:0] free_idx;
    logic [IDX_W-1:0] sel_idx;

    // tag compare against every valid broadcast port
    always_comb
    begin
        s1_hit     = '0;
        s2_hit     = '0;
        new_s1_hit = 1'b0;
        new_s2_hit = 1'b0;
        for (int p = 0; p < `RS_CDB_PORTS; p++)
        begin
            if (cdb.valid[p])
            begin
                for (int i = 0; i < DEPTH; i++)
                begin
                    if (ent[i].ps1 == cdb.tag[p])
                        s1_hit[i] = 1'b1;
                    if (ent[i].ps2 == cdb.tag[p])
                        s2_hit[i] = 1'b1;
                end
                if (disp.ps1 == cdb.tag[p])
                    new_s1_hit = 1'b1;
                if (disp.ps2 == cdb.tag[p])
                    new_s2_hit = 1'b1;
            end
        end
    end

    // lowest free slot and lowest ready slot, scanned top down
    always_comb
    begin
        free_idx = '0;
        sel_idx  = '0;
        req      = 1'b0;
        for (int i = DEPTH - 1; i >= 0; i--)
        begin
            if (!ent[i].busy)
                free_idx = IDX_W'(i);
            if (ent[i].busy && ent[i].ps1_ready && ent[i].ps2_ready)
            begin
                sel_idx = IDX_W'(i);
                req     = 1'b1;
            end
        end
    end

    assign issue_op  = ent[sel_idx].op;
    assign issue_ps1 = ent[sel_idx].ps1;
    assign issue_ps2 = ent[sel_idx].ps2;
    assign issue_pd  = ent[sel_idx].pd;
    assign issue_rob = ent[sel_idx].rob;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < DEPTH; i++)
                ent[i].busy <= 1'b0;
        end
        else
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                if (s1_hit[i])
                    ent[i].ps1_ready <= 1'b1;
                if (s2_hit[i])
                    ent[i].ps2_ready <= 1'b1;
            end
            if (grant)
                ent[sel_idx].busy <= 1'b0;  // free slot never equals the issuing one
            if (disp.write)
            begin
                ent[free_idx] <= '{
                    busy:      1'b1,
                    op:        disp.op,
                    ps1:       disp.ps1,
                    ps1_ready: disp.ps1_ready | new_s1_hit,
                    ps2:       disp.ps2,
                    ps2_ready: disp.ps2_ready | new_s2_hit,
                    pd:        disp.pd,
                    rob:       disp.rob
                };
            end
        end
    end

endmodule

// File: hdl/rs_config.svh
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// physical register tag and ROB index widths
`define RS_TAG_W 6
`define RS_ROB_W 6

// station depth per bank
`define RS_ALU_DEPTH 4
`define RS_MUL_DEPTH 2

// result broadcast ports
`define RS_CDB_PORTS 2

`endif

// File: hdl/rs_control.sv
`timescale 1ns/1ps

module rs_control
    import rs_op_pkg::*;
    import rs_entry_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     dispatch_valid,
    input  opcode_e  dispatch_op,
    input  tag_t     dispatch_ps1,
    input  logic     dispatch_ps1_ready,
    input  tag_t     dispatch_ps2,
    input  logic     dispatch_ps2_ready,
    input  tag_t     dispatch_pd,
    input  rob_idx_t dispatch_rob,

    dispatch_if.source alu_disp,
    dispatch_if.source mul_disp,

    input  logic     alu_req,
    input  logic     mul_req,
    input  logic     alu_fu_busy,
    input  logic     mul_fu_busy,
    output logic     alu_grant,
    output logic     mul_grant,
    output logic     alu_credit,
    output logic     mul_credit
);

    unit_e dispatch_unit;

    assign dispatch_unit = op_unit(dispatch_op);

    // exactly one bank sees the write
    assign alu_disp.write     = dispatch_valid && (dispatch_unit == unit_alu);
    assign alu_disp.op        = dispatch_op;
    assign alu_disp.ps1       = dispatch_ps1;
    assign alu_disp.ps1_ready = dispatch_ps1_ready;
    assign alu_disp.ps2       = dispatch_ps2;
    assign alu_disp.ps2_ready = dispatch_ps2_ready;
    assign alu_disp.pd        = dispatch_pd;
    assign alu_disp.rob       = dispatch_rob;

    assign mul_disp.write     = dispatch_valid && (dispatch_unit == unit_mul);
    assign mul_disp.op        = dispatch_op;
    assign mul_disp.ps1       = dispatch_ps1;
    assign mul_disp.ps1_ready = dispatch_ps1_ready;
    assign mul_disp.ps2       = dispatch_ps2;
    assign mul_disp.ps2_ready = dispatch_ps2_ready;
    assign mul_disp.pd        = dispatch_pd;
    assign mul_disp.rob       = dispatch_rob;

    // a busy unit holds its bank
    assign alu_grant = alu_req && !alu_fu_busy;
    assign mul_grant = mul_req && !mul_fu_busy;

    // one credit back per issued entry, a cycle later
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            alu_credit <= 1'b0;
            mul_credit <= 1'b0;
        end
        else
        begin
            alu_credit <= alu_grant;
            mul_credit <= mul_grant;
        end
    end

endmodule

// File: hdl/rs_entry_pkg.sv
`include "rs_config.svh"

package rs_entry_pkg;
    import rs_op_pkg::*;

    typedef logic [`RS_TAG_W-1:0] tag_t;
    typedef logic [`RS_ROB_W-1:0] rob_idx_t;

    // one reservation station slot
    typedef struct packed {
        logic     busy;      // slot holds a waiting instruction
        opcode_e  op;
        tag_t     ps1;
        logic     ps1_ready;
        tag_t     ps2;
        logic     ps2_ready;
        tag_t     pd;
        rob_idx_t rob;
    } rs_entry_t;

endpackage

// File: hdl/rs_if.sv
`timescale 1ns/1ps
`include "rs_config.svh"

// one renamed instruction headed for a single bank
interface dispatch_if
    import rs_op_pkg::*;
    import rs_entry_pkg::*;
();
    logic     write;   // insert this cycle, credits guarantee a free slot
    opcode_e  op;
    tag_t     ps1;
    logic     ps1_ready;
    tag_t     ps2;
    logic     ps2_ready;
    tag_t     pd;
    rob_idx_t rob;

    modport source (
        output write, op, ps1, ps1_ready, ps2, ps2_ready, pd, rob
    );

    modport sink (
        input write, op, ps1, ps1_ready, ps2, ps2_ready, pd, rob
    );
endinterface

// result tag broadcast, shared by both banks
interface cdb_if
    import rs_entry_pkg::*;
();
    logic [`RS_CDB_PORTS-1:0] valid;
    tag_t                     tag [`RS_CDB_PORTS];

    modport source (
        output valid, tag
    );

    modport sink (
        input valid, tag
    );
endinterface

// File: hdl/rs_op_pkg.sv
package rs_op_pkg;

    // reduced opcode set seen by the issue stage
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_mul,
        op_mulh
    } opcode_e;

    typedef enum logic {
        unit_alu,
        unit_mul
    } unit_e;

    // which bank an opcode is steered to
    function automatic unit_e op_unit(input opcode_e op);
        case (op)
            op_mul, op_mulh: return unit_mul;
            default:         return unit_alu;
        endcase
    endfunction

endpackage

// File: hdl/rs_top.sv
`timescale 1ns/1ps
`include "rs_config.svh"

module rs_top
    import rs_op_pkg::*;
    import rs_entry_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     dispatch_valid,
    input  opcode_e  dispatch_op,
    input  tag_t     dispatch_ps1,
    input  logic     dispatch_ps1_ready,
    input  tag_t     dispatch_ps2,
    input  logic     dispatch_ps2_ready,
    input  tag_t     dispatch_pd,
    input  rob_idx_t dispatch_rob,

    input  logic     cdb0_valid,
    input  tag_t     cdb0_tag,
    input  logic     cdb1_valid,
    input  tag_t     cdb1_tag,

    input  logic     alu_fu_busy,
    input  logic     mul_fu_busy,

    output logic     alu_issue_valid,
    output opcode_e  alu_issue_op,
    output tag_t     alu_issue_ps1,
    output tag_t     alu_issue_ps2,
    output tag_t     alu_issue_pd,
    output rob_idx_t alu_issue_rob,

    output logic     mul_issue_valid,
    output opcode_e  mul_issue_op,
    output tag_t     mul_issue_ps1,
    output tag_t     mul_issue_ps2,
    output tag_t     mul_issue_pd,
    output rob_idx_t mul_issue_rob,

    output logic     alu_credit,
    output logic     mul_credit
);

    logic alu_req;
    logic mul_req;

    dispatch_if alu_disp_if ();
    dispatch_if mul_disp_if ();
    cdb_if      cdb ();

    assign cdb.valid  = {cdb1_valid, cdb0_valid};
    assign cdb.tag[0] = cdb0_tag;
    assign cdb.tag[1] = cdb1_tag;

    rs_control u_control (
        .clk                (clk),
        .rst                (rst),
        .dispatch_valid     (dispatch_valid),
        .dispatch_op        (dispatch_op),
        .dispatch_ps1       (dispatch_ps1),
        .dispatch_ps1_ready (dispatch_ps1_ready),
        .dispatch_ps2       (dispatch_ps2),
        .dispatch_ps2_ready (dispatch_ps2_ready),
        .dispatch_pd        (dispatch_pd),
        .dispatch_rob       (dispatch_rob),
        .alu_disp           (alu_disp_if.source),
        .mul_disp           (mul_disp_if.source),
        .alu_req            (alu_req),
        .mul_req            (mul_req),
        .alu_fu_busy        (alu_fu_busy),
        .mul_fu_busy        (mul_fu_busy),
        .alu_grant          (alu_issue_valid),  // a grant is the issue
        .mul_grant          (mul_issue_valid),
        .alu_credit         (alu_credit),
        .mul_credit         (mul_credit)
    );

    rs_bank #(.DEPTH(`RS_ALU_DEPTH)) u_alu_bank (
        .clk       (clk),
        .rst       (rst),
        .disp      (alu_disp_if.sink),
        .cdb       (cdb.sink),
        .grant     (alu_issue_valid),
        .req       (alu_req),
        .issue_op  (alu_issue_op),
        .issue_ps1 (alu_issue_ps1),
        .issue_ps2 (alu_issue_ps2),
        .issue_pd  (alu_issue_pd),
        .issue_rob (alu_issue_rob)
    );

    rs_bank #(.DEPTH(`RS_MUL_DEPTH)) u_mul_bank (
        .clk       (clk),
        .rst       (rst),
        .disp      (mul_disp_if.sink),
        .cdb       (cdb.sink),
        .grant     (mul_issue_valid),
        .req       (mul_req),
        .issue_op  (mul_issue_op),
        .issue_ps1 (mul_issue_ps1),
        .issue_ps2 (mul_issue_ps2),
        .issue_pd  (mul_issue_pd),
        .issue_rob (mul_issue_rob)
    );

endmodule
